/* Makefile */
SIM = obj_dir/lsu_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module lsu_tb -o lsu_sim

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* design/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 wr_valid,
    input  mem_wr_t              wr,
    input  logic [ram_idx_w-1:0] rd_idx,
    output logic [31:0]          rd_data
);

    logic [31:0] mem [ram_words] = '{default: '0};

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.be[b]) begin
                    mem[wr.idx][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    assign rd_data = mem[rd_idx]; // Same-cycle read, old data during a write

endmodule

`default_nettype wire

/* design/load_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module load_forward import lsu_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     load_valid,
    input  load_req_t                load,
    input  sb_entry_t [sb_depth-1:0] entries,
    output logic [ram_idx_w-1:0]     ram_idx,
    input  logic [31:0]              ram_rdata,
    output logic                     resp_valid,
    output load_resp_t               resp,
    output logic                     order_violation
);

    logic [3:0]       fwd_mask;
    logic [31:0]      fwd_word;
    logic [tag_w-1:0] best_tag;
    logic             viol;

    function automatic logic [31:0] extend(input logic [2:0] f3, input logic [31:0] w);
        case (f3)
            f3_b:    return {{24{w[7]}}, w[7:0]};
            f3_bu:   return {24'h0, w[7:0]};
            f3_h:    return {{16{w[15]}}, w[15:0]};
            f3_hu:   return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    assign ram_idx = load.addr[7:2];

    // Per byte lane, youngest store that is still older than the load
    always_comb begin
        fwd_mask = '0;
        fwd_word = ram_rdata;
        best_tag = '0;
        for (int b = 0; b < 4; b++) begin
            best_tag = '0;
            for (int i = 0; i < sb_depth; i++) begin
                if (entries[i].valid && entries[i].addr == load.addr &&
                    entries[i].tag < load.tag && entries[i].mask[b] &&
                    (!fwd_mask[b] || entries[i].tag > best_tag)) begin
                    fwd_mask[b]          = 1'b1;
                    best_tag             = entries[i].tag;
                    fwd_word[8*b +: 8]   = entries[i].data[8*b +: 8];
                end
            end
        end
    end

    // Younger store already in the buffer, load ran too early
    always_comb begin
        viol = 1'b0;
        for (int i = 0; i < sb_depth; i++) begin
            if (entries[i].valid && entries[i].addr == load.addr &&
                entries[i].tag > load.tag) begin
                viol = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid      <= 1'b0;
            order_violation <= 1'b0;
        end else begin
            resp_valid      <= load_valid;
            order_violation <= load_valid && viol;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            resp <= '{data: extend(load.funct3, fwd_word), phy: load.phy, tag: load.tag};
        end
    end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int sb_depth  = 8;
    localparam int sb_idx_w  = $clog2(sb_depth);
    localparam int tag_w     = 16;
    localparam int phy_w     = 8;
    localparam int ram_words = 64;
    localparam int ram_idx_w = $clog2(ram_words); // Address bits 7:2

    // RV32 load/store funct3 codes
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    typedef struct packed {
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [2:0]       funct3;
        logic [tag_w-1:0] tag;
    } store_req_t;

    typedef struct packed {
        logic [31:0]      addr;
        logic [2:0]       funct3;
        logic [tag_w-1:0] tag;
        logic [phy_w-1:0] phy; // Destination register
    } load_req_t;

    typedef struct packed {
        logic [31:0]      data;
        logic [phy_w-1:0] phy;
        logic [tag_w-1:0] tag;
    } load_resp_t;

    typedef struct packed {
        logic             valid;
        logic             committed;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [3:0]       mask; // One bit per byte lane
        logic [tag_w-1:0] tag;
    } sb_entry_t;

    typedef struct packed {
        logic [ram_idx_w-1:0] idx;
        logic [31:0]          data;
        logic [3:0]           be;
    } mem_wr_t;

endpackage

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             store_valid,
    input  store_req_t       store,
    input  logic             load_valid,
    input  load_req_t        load,
    input  logic             commit_valid,
    input  logic [tag_w-1:0] commit_tag,
    input  logic             flush,
    output logic             sb_full,
    output logic             resp_valid,
    output load_resp_t       resp,
    output logic             order_violation,
    output logic             mem_wr_valid,
    output mem_wr_t          mem_wr
);

    sb_entry_t [sb_depth-1:0] entries;
    logic                     drain_valid;
    logic [sb_idx_w-1:0]      drain_idx;
    logic [ram_idx_w-1:0]     ram_idx;
    logic [31:0]              ram_rdata;

    store_buffer u_sb (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .store_valid  (store_valid),
        .store        (store),
        .load_valid   (load_valid),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .drain_valid  (drain_valid),
        .drain_idx    (drain_idx),
        .entries      (entries),
        .sb_full      (sb_full)
    );

    load_forward u_fwd (
        .clk             (clk),
        .arst_n          (arst_n),
        .load_valid      (load_valid),
        .load            (load),
        .entries         (entries),
        .ram_idx         (ram_idx),
        .ram_rdata       (ram_rdata),
        .resp_valid      (resp_valid),
        .resp            (resp),
        .order_violation (order_violation)
    );

    store_drain u_drain (
        .entries      (entries),
        .drain_valid  (drain_valid),
        .drain_idx    (drain_idx),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr)
    );

    data_ram u_ram (
        .clk      (clk),
        .wr_valid (mem_wr_valid),
        .wr       (mem_wr),
        .rd_idx   (ram_idx),
        .rd_data  (ram_rdata)
    );

endmodule

`default_nettype wire

/* design/store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module store_buffer import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    store_valid,
    input  store_req_t              store,
    input  logic                    load_valid,
    input  logic                    commit_valid,
    input  logic [tag_w-1:0]        commit_tag,
    input  logic                    drain_valid,
    input  logic [sb_idx_w-1:0]     drain_idx,
    output sb_entry_t [sb_depth-1:0] entries,
    output logic                    sb_full
);

    logic [sb_depth-1:0] valid_q;
    logic [sb_depth-1:0] committed_q;
    logic [31:0]         addr_q [sb_depth];
    logic [31:0]         data_q [sb_depth];
    logic [3:0]          mask_q [sb_depth];
    logic [tag_w-1:0]    tag_q  [sb_depth];

    logic                merge_hit;
    logic [sb_idx_w-1:0] merge_idx;
    logic                free_hit;
    logic [sb_idx_w-1:0] free_idx;
    logic [sb_depth-1:0] commit_hit;
    logic [3:0]          new_mask;
    logic                do_store;

    // Word-aligned only, so the size alone gives the lanes
    always_comb begin
        case (store.funct3)
            f3_b:    new_mask = 4'b0001;
            f3_h:    new_mask = 4'b0011;
            default: new_mask = 4'b1111;
        endcase
    end

    // Scan from the top so the lowest index wins
    always_comb begin
        merge_hit = 1'b0;
        merge_idx = '0;
        free_hit  = 1'b0;
        free_idx  = '0;
        for (int i = sb_depth - 1; i >= 0; i--) begin
            if (valid_q[i] && !committed_q[i] && addr_q[i] == store.addr) begin
                merge_hit = 1'b1;
                merge_idx = sb_idx_w'(i);
            end
            if (!valid_q[i]) begin
                free_hit = 1'b1;
                free_idx = sb_idx_w'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < sb_depth; i++) begin
            commit_hit[i] = commit_valid && valid_q[i] && !committed_q[i] &&
                            tag_q[i] == commit_tag;
        end
    end

    assign do_store = store_valid && !flush; // Exception drops a same-cycle store

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q     <= '0;
            committed_q <= '0;
        end else begin
            for (int i = 0; i < sb_depth; i++) begin
                if (commit_hit[i]) begin
                    committed_q[i] <= 1'b1;
                end
            end
            if (drain_valid) begin
                valid_q[drain_idx]     <= 1'b0;
                committed_q[drain_idx] <= 1'b0;
            end
            if (flush) begin
                for (int i = 0; i < sb_depth; i++) begin
                    if (!committed_q[i] && !commit_hit[i]) begin
                        valid_q[i] <= 1'b0;
                    end
                end
            end else if (do_store && !merge_hit && free_hit) begin
                valid_q[free_idx]     <= 1'b1;
                committed_q[free_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_store) begin
            if (merge_hit) begin
                for (int b = 0; b < 4; b++) begin
                    if (new_mask[b]) begin
                        data_q[merge_idx][8*b +: 8] <= store.data[8*b +: 8];
                    end
                end
                mask_q[merge_idx] <= mask_q[merge_idx] | new_mask;
                tag_q[merge_idx]  <= store.tag; // Merged entry carries the newer tag
            end else if (free_hit) begin
                addr_q[free_idx] <= store.addr;
                data_q[free_idx] <= store.data;
                mask_q[free_idx] <= new_mask;
                tag_q[free_idx]  <= store.tag;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < sb_depth; i++) begin
            entries[i].valid     = valid_q[i];
            entries[i].committed = committed_q[i];
            entries[i].addr      = addr_q[i];
            entries[i].data      = data_q[i];
            entries[i].mask      = mask_q[i];
            entries[i].tag       = tag_q[i];
        end
    end

    assign sb_full = &valid_q;

    a_no_store_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) store_valid |-> !sb_full
    ) else $error("store strobed while buffer full");

    a_store_load_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(store_valid && load_valid)
    ) else $error("store and load strobed together");

endmodule

`default_nettype wire

/* design/store_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module store_drain import lsu_pkg::*; (
    input  sb_entry_t [sb_depth-1:0] entries,
    output logic                     drain_valid,
    output logic [sb_idx_w-1:0]      drain_idx,
    output logic                     mem_wr_valid,
    output mem_wr_t                  mem_wr
);

    logic [tag_w-1:0] oldest_tag;
    sb_entry_t        sel;

    // Oldest committed entry goes out first
    always_comb begin
        drain_valid = 1'b0;
        drain_idx   = '0;
        oldest_tag  = '0;
        for (int i = 0; i < sb_depth; i++) begin
            if (entries[i].valid && entries[i].committed &&
                (!drain_valid || entries[i].tag < oldest_tag)) begin
                drain_valid = 1'b1;
                drain_idx   = sb_idx_w'(i);
                oldest_tag  = entries[i].tag;
            end
        end
    end

    assign sel = entries[drain_idx];

    assign mem_wr_valid = drain_valid;
    assign mem_wr.idx   = sel.addr[7:2];
    assign mem_wr.data  = sel.data;
    assign mem_wr.be    = sel.mask; // Merged lanes only

endmodule

`default_nettype wire

/* sim/lsu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_checker import lsu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        exp_ld_valid,
    input  load_resp_t  exp_ld,
    input  logic        exp_ld_viol,
    input  logic        exp_wr_valid,
    input  mem_wr_t     exp_wr,
    input  logic        exp_full_valid,
    input  logic        exp_full,
    input  logic        resp_valid,
    input  load_resp_t  resp,
    input  logic        order_violation,
    input  logic        mem_wr_valid,
    input  mem_wr_t     mem_wr,
    input  logic        sb_full,
    output int          pending_wr,
    output int          errors
);

    load_resp_t ld_q   [$];
    logic       viol_q [$];
    mem_wr_t    wr_q   [$];

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        load_resp_t ld_exp;
        logic       viol_exp;
        mem_wr_t    wr_exp;
        if (!arst_n) begin
            errors     = 0;
            pending_wr = 0;
        end else begin
            // Response is due exactly one cycle after the load was sampled
            if (ld_q.size() != 0) begin
                ld_exp   = ld_q.pop_front();
                viol_exp = viol_q.pop_front();
                if (!resp_valid) begin
                    $display("%0t: no load response one cycle after the load", $time);
                    errors++;
                end else if (resp !== ld_exp || order_violation !== viol_exp) begin
                    $display("Mismatch at %0t: load %h/%h/%h/%b, expected %h/%h/%h/%b",
                             $time, resp.data, resp.phy, resp.tag, order_violation,
                             ld_exp.data, ld_exp.phy, ld_exp.tag, viol_exp);
                    errors++;
                end
            end else if (resp_valid) begin
                $display("%0t: load response with no load one cycle earlier", $time);
                errors++;
            end else if (order_violation) begin
                $display("Mismatch at %0t: order violation without a load response", $time);
                errors++;
            end
            if (exp_ld_valid) begin
                ld_q.push_back(exp_ld);
                viol_q.push_back(exp_ld_viol);
            end
            if (exp_wr_valid) wr_q.push_back(exp_wr);
            if (mem_wr_valid) begin
                if (wr_q.size() == 0) begin
                    $display("%0t: RAM write to word %0d was not expected", $time, mem_wr.idx);
                    errors++;
                end else begin
                    wr_exp = wr_q.pop_front();
                    if (mem_wr.idx !== wr_exp.idx || mem_wr.be !== wr_exp.be ||
                        (mem_wr.data & lane_mask(wr_exp.be)) !== wr_exp.data) begin
                        $display("Mismatch at %0t: RAM write %0d/%h/%b, expected %0d/%h/%b",
                                 $time, mem_wr.idx, mem_wr.data, mem_wr.be,
                                 wr_exp.idx, wr_exp.data, wr_exp.be);
                        errors++;
                    end
                end
            end
            if (exp_full_valid && sb_full !== exp_full) begin
                $display("Mismatch at %0t: sb_full is %b, expected %b", $time, sb_full, exp_full);
                errors++;
            end
            pending_wr = wr_q.size();
        end
    end

endmodule

`default_nettype wire

/* sim/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    typedef enum {op_store, op_load, op_commit, op_flush, op_idle, op_wait, op_full} op_t;

    typedef struct {
        op_t              op;
        logic [2:0]       f3;
        logic [31:0]      addr;
        logic [31:0]      data; // Store data, or expected write data for a commit
        logic [tag_w-1:0] tag;
        logic [3:0]       be;
        logic [31:0]      exp_data;
        logic             exp_viol;
    } step_t;

    logic             clk;
    logic             arst_n;
    logic             store_valid;
    store_req_t       store;
    logic             load_valid;
    load_req_t        load;
    logic             commit_valid;
    logic [tag_w-1:0] commit_tag;
    logic             flush;
    logic             sb_full;
    logic             resp_valid;
    load_resp_t       resp;
    logic             order_violation;
    logic             mem_wr_valid;
    mem_wr_t          mem_wr;

    logic             exp_ld_valid;
    load_resp_t       exp_ld;
    logic             exp_ld_viol;
    logic             exp_wr_valid;
    mem_wr_t          exp_wr;
    logic             exp_full_valid;
    logic             exp_full;
    int               pending_wr;
    int               errors;
    int               timeouts;
    int               waited;
    step_t            steps [$];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    lsu_top u_dut (
        .clk(clk), .arst_n(arst_n), .store_valid(store_valid), .store(store),
        .load_valid(load_valid), .load(load), .commit_valid(commit_valid),
        .commit_tag(commit_tag), .flush(flush), .sb_full(sb_full),
        .resp_valid(resp_valid), .resp(resp), .order_violation(order_violation),
        .mem_wr_valid(mem_wr_valid), .mem_wr(mem_wr)
    );

    lsu_checker u_chk (
        .clk(clk), .arst_n(arst_n), .exp_ld_valid(exp_ld_valid),
        .exp_ld(exp_ld), .exp_ld_viol(exp_ld_viol),
        .exp_wr_valid(exp_wr_valid), .exp_wr(exp_wr),
        .exp_full_valid(exp_full_valid), .exp_full(exp_full),
        .resp_valid(resp_valid), .resp(resp), .order_violation(order_violation),
        .mem_wr_valid(mem_wr_valid), .mem_wr(mem_wr), .sb_full(sb_full),
        .pending_wr(pending_wr), .errors(errors)
    );

    function automatic logic [phy_w-1:0] phy_from_tag(input logic [tag_w-1:0] tag);
        return phy_w'(tag + tag_w'(64)); // Differs from the low tag bits
    endfunction

    task automatic add(input op_t op, input logic [2:0] f3, input logic [31:0] addr,
                       input logic [31:0] data, input int tag, input logic [3:0] be,
                       input logic [31:0] exp_data, input logic exp_viol);
        steps.push_back('{op, f3, addr, data, tag_w'(tag), be, exp_data, exp_viol});
    endtask

    task automatic build_table();
        // Forwarding and extension
        add(op_store,  f3_w,  32'h10, 32'h8081_8283, 5,  4'h0, 32'h0, 1'b0);
        add(op_load,   f3_b,  32'h10, 32'h0,         9,  4'h0, 32'hFFFF_FF83, 1'b0);
        add(op_load,   f3_bu, 32'h10, 32'h0,         9,  4'h0, 32'h0000_0083, 1'b0);
        add(op_load,   f3_h,  32'h10, 32'h0,         9,  4'h0, 32'hFFFF_8283, 1'b0);
        add(op_load,   f3_w,  32'h10, 32'h0,         9,  4'h0, 32'h8081_8283, 1'b0);
        // Merge into one entry, upper bytes from RAM
        add(op_store,  f3_b,  32'h20, 32'h0000_00AA, 10, 4'h0, 32'h0, 1'b0);
        add(op_store,  f3_h,  32'h20, 32'h0000_1234, 11, 4'h0, 32'h0, 1'b0);
        add(op_load,   f3_w,  32'h20, 32'h0,         12, 4'h0, 32'h0000_1234, 1'b0);
        add(op_full,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        for (int i = 0; i < 5; i++) begin
            add(op_store, f3_w, 32'h40 + 32'(4 * i), 32'h1111_0000 + 32'(i), 20 + i,
                4'h0, 32'h0, 1'b0);
        end
        add(op_full,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        add(op_store,  f3_w,  32'h54, 32'h1111_0005, 25, 4'h0, 32'h0, 1'b0);
        add(op_full,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h1, 1'b0);
        // Older load behind a younger store
        add(op_load,   f3_w,  32'h10, 32'h0,         3,  4'h0, 32'h0, 1'b1);
        // Commit and drain in tag order
        add(op_commit, f3_w,  32'h10, 32'h8081_8283, 5,  4'hF, 32'h0, 1'b0);
        add(op_commit, f3_w,  32'h20, 32'h0000_1234, 11, 4'h3, 32'h0, 1'b0);
        add(op_commit, f3_w,  32'h40, 32'h1111_0000, 20, 4'hF, 32'h0, 1'b0);
        add(op_wait,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        add(op_load,   f3_w,  32'h10, 32'h0,         30, 4'h0, 32'h8081_8283, 1'b0);
        add(op_load,   f3_hu, 32'h20, 32'h0,         30, 4'h0, 32'h0000_1234, 1'b0);
        add(op_load,   f3_w,  32'h40, 32'h0,         30, 4'h0, 32'h1111_0000, 1'b0);
        // Flush keeps the committed store
        add(op_commit, f3_w,  32'h44, 32'h1111_0001, 21, 4'hF, 32'h0, 1'b0);
        add(op_flush,  f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        add(op_wait,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        add(op_load,   f3_w,  32'h48, 32'h0,         40, 4'h0, 32'h0, 1'b0);
        add(op_load,   f3_w,  32'h44, 32'h0,         40, 4'h0, 32'h1111_0001, 1'b0);
        add(op_full,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        add(op_idle,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
        add(op_idle,   f3_w,  32'h0,  32'h0,         0,  4'h0, 32'h0, 1'b0);
    endtask

    task automatic drive_idle();
        store_valid    <= 1'b0;
        load_valid     <= 1'b0;
        commit_valid   <= 1'b0;
        flush          <= 1'b0;
        exp_ld_valid   <= 1'b0;
        exp_wr_valid   <= 1'b0;
        exp_full_valid <= 1'b0;
    endtask

    initial begin
        arst_n = 1'b0;
        store_valid = 1'b0;
        store = '0;
        load_valid = 1'b0;
        load = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        flush = 1'b0;
        exp_ld_valid = 1'b0;
        exp_ld = '0;
        exp_ld_viol = 1'b0;
        exp_wr_valid = 1'b0;
        exp_wr = '0;
        exp_full_valid = 1'b0;
        exp_full = 1'b0;
        timeouts = 0;
        build_table();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        foreach (steps[i]) begin
            @(posedge clk);
            drive_idle();
            case (steps[i].op)
                op_store: begin
                    store_valid <= 1'b1;
                    store <= '{addr: steps[i].addr, data: steps[i].data,
                               funct3: steps[i].f3, tag: steps[i].tag};
                end
                op_load: begin
                    load_valid <= 1'b1;
                    load <= '{addr: steps[i].addr, funct3: steps[i].f3,
                              tag: steps[i].tag, phy: phy_from_tag(steps[i].tag)};
                    exp_ld_valid <= 1'b1;
                    exp_ld <= '{data: steps[i].exp_data, phy: phy_from_tag(steps[i].tag),
                                tag: steps[i].tag};
                    exp_ld_viol  <= steps[i].exp_viol;
                end
                op_commit: begin
                    commit_valid <= 1'b1;
                    commit_tag   <= steps[i].tag;
                    exp_wr_valid <= 1'b1;
                    exp_wr <= '{idx: steps[i].addr[7:2], data: steps[i].data,
                                be: steps[i].be};
                end
                op_flush: flush <= 1'b1;
                op_full: begin
                    exp_full_valid <= 1'b1;
                    exp_full       <= steps[i].exp_data[0];
                end
                op_wait: begin
                    waited = 0;
                    @(negedge clk);
                    while (pending_wr != 0 && waited < 50) begin
                        @(negedge clk);
                        waited++;
                    end
                    if (pending_wr != 0) begin
                        $display("%0t: committed store drain never happened", $time);
                        timeouts++;
                    end
                end
                default: ;
            endcase
        end
        @(posedge clk);
        drive_idle();
        repeat (2) @(negedge clk);
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/lsu_pkg.sv
design/store_buffer.sv
design/load_forward.sv
design/store_drain.sv
design/data_ram.sv
design/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv
